// ==== files.f ====
design/mips_pkg.sv
design/mem_pkg.sv
design/mem_access.sv
design/data_ram.sv
design/load_align.sv
design/wb_regfile.sv
design/mem_wb_top.sv
sim/tb_mem_wb.sv

// ==== Bender.yml ====
package:
  name: mem_wb

dependencies: {}

sources:
  # packages come first, the request type uses the word type.
  - files:
      - design/mips_pkg.sv
      - design/mem_pkg.sv
      - design/mem_access.sv
      - design/data_ram.sv
      - design/load_align.sv
      - design/wb_regfile.sv
      - design/mem_wb_top.sv

  # testbench, top module tb_mem_wb.
  - target: test
    files:
      - sim/tb_mem_wb.sv

// ==== sim/tb_mem_wb.sv ====
// ----------------------------------------------------------
// Testbench for the memory-access and write-back subsystem:
// clock and reset, a table of execute results with expected
// write-back and register values, reference load rules,
// compare tasks and a cycle-count timeout.
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_mem_wb;
    import mips_pkg::*;

    localparam int unsigned ADDR_BITS = 8;

    logic       clk;
    logic       arst_n;
    ex_result_t ex_in;
    wb_t        wb_out;
    reg_idx_t   rd_idx;
    word_t      rd_data;

    ex_result_t tab_ex [$];
    wb_t        tab_wb [$];
    logic       tab_chk [$];
    reg_idx_t   tab_idx [$];
    word_t      tab_val [$];

    word_t  ref_mem [2**ADDR_BITS]; // expected RAM contents as the queued stores leave them.
    integer seed;
    int     cycles;
    int     cycle_limit;

    mem_wb_top #(
        .ADDR_BITS (ADDR_BITS)
    ) u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .ex_in   (ex_in),
        .wb_out  (wb_out),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "write-back mismatch");
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "register read mismatch");
        end
    endtask

    // what a load returns from word w at byte offset off.
    function automatic word_t load_result(input alu_op_e op, input word_t w,
                                          input logic [1:0] off);
        logic [7:0]  b [4];
        logic [15:0] h;
        word_t       r;
        int          o;
        o = off;
        for (int k = 0; k < 4; k++) begin
            b[k] = w[8*k +: 8];
        end
        h = off[1] ? w[31:16] : w[15:0];
        r = '0;
        case (op)
            OP_LB:  r = {{24{b[o][7]}}, b[o]};
            OP_LBU: r = {24'h0, b[o]};
            OP_LH:  r = off[0] ? 32'h0 : {{16{h[15]}}, h};
            OP_LHU: r = off[0] ? 32'h0 : {16'h0, h};
            OP_LW:  r = w;
            OP_LWL: begin
                for (int k = 0; k <= o; k++) begin
                    r[8*(k + 3 - o) +: 8] = b[k];
                end
            end
            OP_LWR: begin
                for (int k = o; k < 4; k++) begin
                    r[8*(k - o) +: 8] = b[k];
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic model_store(input alu_op_e op, input word_t addr, input word_t data);
        int unsigned wa;
        wa = addr[ADDR_BITS+1:2];
        case (op)
            OP_SB: ref_mem[wa][8*addr[1:0] +: 8] = data[7:0];
            OP_SH: ref_mem[wa][16*addr[1] +: 16] = data[15:0];
            default: ref_mem[wa] = data;
        endcase
    endtask

    task automatic add_entry(input logic valid, input alu_op_e op, input word_t alures,
                             input word_t sdata, input reg_idx_t dest, input logic chk);
        ex_result_t ex;
        wb_t        exp;
        logic       loads;
        loads     = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
        ex.valid      = valid;
        ex.op         = op;
        ex.alures     = alures;
        ex.store_data = sdata;
        ex.dest       = dest;
        exp.valid = valid && (loads || op == OP_ALU);
        exp.dest  = dest;
        exp.data  = loads ? load_result(op, ref_mem[alures[ADDR_BITS+1:2]], alures[1:0])
                          : alures;
        if (valid && op inside {OP_SB, OP_SH, OP_SW}) begin
            model_store(op, alures, sdata);
        end
        tab_ex.push_back(ex);
        tab_wb.push_back(exp);
        tab_chk.push_back(chk);
        tab_idx.push_back(dest);
        tab_val.push_back((dest == '0) ? word_t'(0) : exp.data);
    endtask

    task automatic build_table();
        word_t known;
        known = 32'h80f1_7f2c; // bytes and halfwords of both signs.
        add_entry(1, OP_ALU, 32'h1234_5678, '0, 5'd5, 1);
        add_entry(1, OP_ALU, 32'hdead_beef, '0, 5'd0, 1); // register 0 stays zero.
        add_entry(1, OP_ALU, 32'h0bad_f00d, '0, 5'd31, 1);
        for (int k = 0; k < 4; k++) begin
            add_entry(1, OP_SW, 32'h40 + 4*k, $random(seed), 5'd0, 0);
        end
        add_entry(1, OP_SH, 32'h46, $random(seed), 5'd0, 0);
        add_entry(1, OP_SB, 32'h49, $random(seed), 5'd0, 0);
        add_entry(1, OP_SB, 32'h4f, $random(seed), 5'd0, 0);
        add_entry(1, OP_SH, 32'h40, $random(seed), 5'd0, 0);
        for (int k = 0; k < 4; k++) begin
            add_entry(1, OP_LW, 32'h40 + 4*k, '0, reg_idx_t'(6 + k), 1);
        end
        add_entry(1, OP_SW, 32'h50, $random(seed), 5'd0, 0);
        add_entry(1, OP_LW, 32'h50, '0, 5'd10, 1); // load right after the store.
        add_entry(1, OP_SW, 32'h80, known, 5'd0, 0);
        for (int k = 0; k < 4; k++) begin
            add_entry(1, OP_LB, 32'h80 + k, '0, reg_idx_t'(16 + k), 1);
            add_entry(1, OP_LBU, 32'h80 + k, '0, reg_idx_t'(20 + k), 1);
            add_entry(1, OP_LH, 32'h80 + k, '0, reg_idx_t'(24 + k), 1);
            add_entry(1, OP_LHU, 32'h80 + k, '0, reg_idx_t'(28 + k), 1);
        end
        for (int k = 0; k < 4; k++) begin
            add_entry(1, OP_LWL, 32'h80 + k, '0, reg_idx_t'(11 + k), 1);
            add_entry(1, OP_LWR, 32'h80 + k, '0, reg_idx_t'(1 + k), 1);
        end
        add_entry(1, OP_ALU, 32'h0000_00aa, '0, 5'd3, 1);
        add_entry(1, OP_SW, 32'h84, 32'hcafe_0123, 5'd0, 0);
        add_entry(1, OP_LW, 32'h84, '0, 5'd4, 1);
        add_entry(1, OP_SB, 32'h86, 32'h0000_0099, 5'd0, 0);
        add_entry(1, OP_LBU, 32'h86, '0, 5'd7, 1);
        add_entry(0, OP_ALU, 32'h5555_aaaa, '0, 5'd8, 0);
        add_entry(1, OP_SH, 32'h84, 32'h0000_8001, 5'd0, 0);
        add_entry(1, OP_LH, 32'h84, '0, 5'd9, 1);
        add_entry(1, OP_LWL, 32'h85, '0, 5'd13, 1);
        add_entry(1, OP_ALU, 32'hffff_fffe, '0, 5'd14, 1);
        add_entry(1, OP_LWR, 32'h87, '0, 5'd15, 1);
    endtask

    initial begin
        int n;
        clk         = 1'b0;
        arst_n      = 1'b0;
        ex_in       = '0;
        rd_idx      = '0;
        cycles      = 0;
        cycle_limit = 0;
        seed        = 32'hb87b_13fa;
        build_table();
        n           = tab_ex.size();
        cycle_limit = 2 * n + 50;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int r = 0; r < 32; r++) begin
            rd_idx = reg_idx_t'(r);
            @(negedge clk);
            check_wb("wb_out", '0, wb_out);
            check_word("rd_data", '0, rd_data);
        end

        // wb_out lags the drive by one cycle and the register read by two.
        for (int i = 0; i < n + 2; i++) begin
            if (i >= 1 && i <= n) begin
                check_wb("wb_out", tab_wb[i-1], wb_out);
            end
            if (i >= 2 && tab_chk[i-2]) begin
                check_word("rd_data", tab_val[i-2], rd_data);
            end
            if (i >= 1 && i <= n) begin
                rd_idx = tab_idx[i-1];
            end
            ex_in = (i < n) ? tab_ex[i] : ex_result_t'(0);
            @(negedge clk);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== design/mem_wb_top.sv ====
// ----------------------------------------------------------
// Memory-access and write-back subsystem: memory stage,
// data RAM, load aligner and register file.
// ----------------------------------------------------------
`timescale 1ns/1ps

module mem_wb_top #(
    parameter int unsigned ADDR_BITS = 8
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  mips_pkg::ex_result_t ex_in,
    output mips_pkg::wb_t        wb_out,
    input  mips_pkg::reg_idx_t   rd_idx,
    output mips_pkg::word_t      rd_data
);
    import mips_pkg::*;
    import mem_pkg::*;

    ram_req_t ram_req;
    mem_ctx_t ctx;
    word_t    rdata;
    wb_t      wb;

    mem_access #(
        .ADDR_BITS (ADDR_BITS)
    ) u_mem_access (
        .clk     (clk),
        .arst_n  (arst_n),
        .ex_in   (ex_in),
        .ram_req (ram_req),
        .ctx     (ctx)
    );

    data_ram #(
        .ADDR_BITS (ADDR_BITS)
    ) u_data_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .rdata   (rdata)
    );

    load_align u_load_align (
        .ctx   (ctx),
        .rdata (rdata),
        .wb    (wb)
    );

    wb_regfile u_wb_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb      (wb),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    assign wb_out = wb;

endmodule

// ==== design/wb_regfile.sv ====
// ----------------------------------------------------------
// Write-back register file: 32 words, register 0 fixed at
// zero, one write port and one combinational read port.
// ----------------------------------------------------------
`timescale 1ns/1ps

module wb_regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  mips_pkg::wb_t      wb,
    input  mips_pkg::reg_idx_t rd_idx,
    output mips_pkg::word_t    rd_data
);
    import mips_pkg::*;

    localparam int unsigned NUM_REGS = 32;

    word_t regs [NUM_REGS];
    logic  wr_en;

    assign wr_en = wb.valid && (wb.dest != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // new data shows from the cycle after the write.
    assign rd_data = (rd_idx == '0) ? '0 : regs[rd_idx];

endmodule

// ==== design/load_align.sv ====
// ----------------------------------------------------------
// Load aligner: picks the byte, halfword or word a load
// returns, with sign or zero extension and the partial
// LWL/LWR forms, and selects it or the ALU result for
// write-back.
// ----------------------------------------------------------
`timescale 1ns/1ps

module load_align (
    input  mips_pkg::mem_ctx_t ctx,
    input  mips_pkg::word_t    rdata,
    output mips_pkg::wb_t      wb
);
    import mips_pkg::*;

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;
    logic [4:0]  shift_up;
    logic [4:0]  shift_down;
    logic        half_ok;
    word_t       load_data;
    logic        mem_to_reg;

    assign lane_byte  = rdata[{ctx.addr_lo, 3'b000} +: 8];
    assign lane_half  = rdata[{ctx.addr_lo[1], 4'b0000} +: 16];
    assign half_ok    = ~ctx.addr_lo[0];            // odd halfword offsets give zero.
    assign shift_up   = {~ctx.addr_lo, 3'b000};     // LWL moves the low bytes to the top.
    assign shift_down = {ctx.addr_lo, 3'b000};      // LWR moves the high bytes down.

    always_comb begin
        mem_to_reg = is_load(ctx.op);
        case (ctx.op)
            OP_LB: begin
                load_data = {{24{lane_byte[7]}}, lane_byte};
            end
            OP_LBU: begin
                load_data = {24'b0, lane_byte};
            end
            OP_LH: begin
                load_data = half_ok ? {{16{lane_half[15]}}, lane_half} : '0;
            end
            OP_LHU: begin
                load_data = half_ok ? {16'b0, lane_half} : '0;
            end
            OP_LW: begin
                load_data = rdata;
            end
            OP_LWL: begin
                load_data = rdata << shift_up;
            end
            OP_LWR: begin
                load_data = rdata >> shift_down;
            end
            default: begin
                load_data = '0;
            end
        endcase
    end

    always_comb begin
        wb.valid = ctx.valid && (mem_to_reg || ctx.op == OP_ALU); // stores write nothing.
        wb.dest  = ctx.dest;
        wb.data  = mem_to_reg ? load_data : ctx.alures;
    end

    // a misaligned LW is a protocol error of the execute stage.
    a_lw_aligned: assert final (!(ctx.valid && ctx.op == OP_LW) || ctx.addr_lo == 2'b00)
        else $error("load_align: LW with byte offset %0d", ctx.addr_lo);

endmodule

// ==== design/data_ram.sv ====
// ----------------------------------------------------------
// Synchronous data RAM: byte-writable words, one-cycle
// registered read, read-first on a same-address write.
// ----------------------------------------------------------
`timescale 1ns/1ps

module data_ram #(
    parameter int unsigned ADDR_BITS = 8
) (
    input  logic              clk,
    input  mem_pkg::ram_req_t ram_req,
    output mips_pkg::word_t   rdata
);
    import mips_pkg::*;
    import mem_pkg::*;

    localparam int unsigned DEPTH = 2 ** ADDR_BITS;

    word_t                mem [DEPTH];
    logic [ADDR_BITS-1:0] addr;

    assign addr = ram_req.word_addr[ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (ram_req.we[lane]) begin
                    mem[addr][8*lane +: 8] <= ram_req.wdata[8*lane +: 8];
                end
            end
            rdata <= mem[addr]; // the read returns the old contents before the write lands.
        end
    end

    a_we_needs_en: assert property (@(posedge clk)
        (ram_req.we != BE_NONE) |-> ram_req.en)
        else $error("data_ram: byte write enables %b without en", ram_req.we);

endmodule

// ==== design/mem_access.sv ====
// ----------------------------------------------------------
// Memory-access stage: decodes loads and stores into a RAM
// request with placed byte enables and lane-aligned store
// data, and registers the context used by the load aligner.
// ----------------------------------------------------------
`timescale 1ns/1ps

module mem_access #(
    parameter int unsigned ADDR_BITS = 8
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  mips_pkg::ex_result_t ex_in,
    output mem_pkg::ram_req_t    ram_req,
    output mips_pkg::mem_ctx_t   ctx
);
    import mips_pkg::*;
    import mem_pkg::*;

    logic [ADDR_BITS-1:0] word_addr;
    logic [1:0]           byte_off;

    assign word_addr = ex_in.alures[ADDR_BITS+1:2];
    assign byte_off  = ex_in.alures[1:0];

    always_comb begin
        ram_req.en        = ex_in.valid && (is_load(ex_in.op) || is_store(ex_in.op));
        ram_req.we        = BE_NONE;
        ram_req.word_addr = ram_addr_t'(word_addr);
        ram_req.wdata     = ex_in.store_data;
        if (ex_in.valid) begin
            case (ex_in.op)
                OP_SB: begin
                    ram_req.we    = byte_en_t'(4'b0001 << byte_off);
                    ram_req.wdata = {4{ex_in.store_data[7:0]}};
                end
                OP_SH: begin
                    ram_req.we    = byte_off[1] ? BE_HI_H : BE_LO_H;
                    ram_req.wdata = {2{ex_in.store_data[15:0]}};
                end
                OP_SW: begin
                    ram_req.we = BE_ALL;
                end
                default: begin
                    ram_req.we = BE_NONE; // loads and ALU results write nothing.
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctx <= '0;
        end else begin
            ctx.valid   <= ex_in.valid;
            ctx.op      <= ex_in.op;
            ctx.addr_lo <= byte_off;
            ctx.alures  <= ex_in.alures;
            ctx.dest    <= ex_in.dest;
        end
    end

    a_sh_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (ex_in.valid && ex_in.op == OP_SH) |-> ex_in.alures[0] == 1'b0)
        else $error("mem_access: misaligned SH to address %h", ex_in.alures);

    a_sw_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (ex_in.valid && ex_in.op == OP_SW) |-> ex_in.alures[1:0] == 2'b00)
        else $error("mem_access: misaligned SW to address %h", ex_in.alures);

endmodule

// ==== design/mem_pkg.sv ====
// ----------------------------------------------------------
// Data-RAM request types: byte-lane enables and the request
// struct that the memory stage sends to the RAM.
// ----------------------------------------------------------
package mem_pkg;

    // widest word address the request can carry.
    localparam int unsigned RAM_ADDR_MAX_BITS = 16;

    typedef logic [3:0]                   byte_en_t;
    typedef logic [RAM_ADDR_MAX_BITS-1:0] ram_addr_t;

    localparam byte_en_t BE_NONE = 4'b0000;
    localparam byte_en_t BE_LO_H = 4'b0011;
    localparam byte_en_t BE_HI_H = 4'b1100;
    localparam byte_en_t BE_ALL  = 4'b1111;

    typedef struct packed {
        logic           en;
        byte_en_t       we;        // one bit per byte lane with lane 0 on bits 7:0.
        ram_addr_t      word_addr; // upper bits are zero for smaller RAMs.
        mips_pkg::word_t wdata;
    } ram_req_t;

endpackage

// ==== design/mips_pkg.sv ====
// ----------------------------------------------------------
// Pipeline-level types for the memory and write-back end:
// data word and register index, the operation enum, the
// execute result, the memory-stage context and write-back.
// ----------------------------------------------------------
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        OP_ALU = 4'h0, // any result that does not touch memory.
        OP_LB  = 4'h1,
        OP_LBU = 4'h2,
        OP_LH  = 4'h3,
        OP_LHU = 4'h4,
        OP_LW  = 4'h5,
        OP_LWL = 4'h6,
        OP_LWR = 4'h7,
        OP_SB  = 4'h8,
        OP_SH  = 4'h9,
        OP_SW  = 4'ha
    } alu_op_e;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        word_t    alures;     // effective address for loads and stores.
        word_t    store_data;
        reg_idx_t dest;
    } ex_result_t;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        logic [1:0] addr_lo;  // byte offset of the access.
        word_t    alures;
        reg_idx_t dest;
    } mem_ctx_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest;
        word_t    data;
    } wb_t;

    function automatic logic is_load(alu_op_e op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
    endfunction

    function automatic logic is_store(alu_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

endpackage
